//--- hdl/exec_macros.svh
// execute stage sizing macros shared by the packages and function units
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// data path word, also the hi and lo register width
`define EXEC_WORD_W   32

// shift amount, taken from the low bits of A
`define EXEC_SHAMT_W  5

// one partial product or quotient bit per step
`define EXEC_MD_STEPS 32

`endif

//--- hdl/exec_op_pkg.sv
// execute stage operation package: opcode and operand select encodings
`default_nettype none

package exec_op_pkg;

    typedef enum logic [4:0] {
        ALU_NOP   = 5'd0,
        ALU_PA    = 5'd1,   // pass A
        ALU_PB    = 5'd2,   // pass B
        ALU_ADD   = 5'd3,
        ALU_SUB   = 5'd4,
        ALU_AND   = 5'd5,
        ALU_OR    = 5'd6,
        ALU_XOR   = 5'd7,
        ALU_NOR   = 5'd8,
        ALU_SLT   = 5'd9,   // signed compare
        ALU_SLTU  = 5'd10,  // unsigned compare
        ALU_SLL   = 5'd11,
        ALU_SRL   = 5'd12,
        ALU_SRA   = 5'd13,
        ALU_MULT  = 5'd14,
        ALU_MULTU = 5'd15,
        ALU_DIV   = 5'd16,
        ALU_DIVU  = 5'd17,
        ALU_MFHI  = 5'd18,
        ALU_MFLO  = 5'd19,
        ALU_MTHI  = 5'd20,  // hi <= A
        ALU_MTLO  = 5'd21   // lo <= A
    } alu_op_e;

    typedef enum logic {
        A_RS  = 1'b0,
        A_IMM = 1'b1
    } a_sel_e;

    typedef enum logic {
        B_RT  = 1'b0,
        B_IMM = 1'b1
    } b_sel_e;

    // register file value, or bypass from a later stage
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_ALU = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

endpackage

`default_nettype wire

//--- hdl/exec_data_pkg.sv
// execute stage data package: word, double word and hi/lo pair types
`default_nettype none
`include "exec_macros.svh"

package exec_data_pkg;

    typedef logic [`EXEC_WORD_W-1:0]   word_t;   // one register value
    typedef logic [2*`EXEC_WORD_W-1:0] dword_t;  // full product width

    typedef struct packed {
        word_t hi;  // upper product word or remainder
        word_t lo;  // lower product word or quotient
    } hilo_t;

endpackage

`default_nettype wire

//--- hdl/exec_operand_if.sv
// issued operation and resolved operands, fanned out to the function units
`default_nettype none

interface exec_operand_if;

    logic                 valid;  // one-cycle issue strobe
    exec_op_pkg::alu_op_e op;
    exec_data_pkg::word_t a;
    exec_data_pkg::word_t b;

    modport src (
        output valid,
        output op,
        output a,
        output b
    );

    modport unit (
        input valid,
        input op,
        input a,
        input b
    );

endinterface

`default_nettype wire

//--- hdl/operand_select.sv
// operand select: register forwarding and A/B/store data multiplexing
`default_nettype none

module operand_select (
    input  wire exec_op_pkg::a_sel_e   a_sel_i,
    input  wire exec_op_pkg::b_sel_e   b_sel_i,
    input  wire exec_op_pkg::fwd_sel_e fwd_a_i,
    input  wire exec_op_pkg::fwd_sel_e fwd_b_i,
    input  wire                        valid_i,
    input  wire exec_op_pkg::alu_op_e  op_i,
    input  wire exec_data_pkg::word_t  rs_i,
    input  wire exec_data_pkg::word_t  rt_i,
    input  wire exec_data_pkg::word_t  imm_i,
    input  wire exec_data_pkg::word_t  fw_alu_i,
    input  wire exec_data_pkg::word_t  fw_mem_i,
    output exec_data_pkg::word_t       store_data_o,
    exec_operand_if.src                opnd
);

    exec_data_pkg::word_t rs_fwd;  // rs after bypass
    exec_data_pkg::word_t rt_fwd;  // rt after bypass

    // pick one register operand from the file or a later stage
    function automatic exec_data_pkg::word_t fwd_pick(
        input exec_op_pkg::fwd_sel_e sel,
        input exec_data_pkg::word_t  reg_val,
        input exec_data_pkg::word_t  alu_val,
        input exec_data_pkg::word_t  mem_val
    );
        case (sel)
            exec_op_pkg::FWD_ALU: return alu_val;
            exec_op_pkg::FWD_MEM: return mem_val;
            default:              return reg_val;
        endcase
    endfunction

    assign rs_fwd = fwd_pick(fwd_a_i, rs_i, fw_alu_i, fw_mem_i);
    assign rt_fwd = fwd_pick(fwd_b_i, rt_i, fw_alu_i, fw_mem_i);

    assign opnd.a = (a_sel_i == exec_op_pkg::A_IMM) ? imm_i : rs_fwd;
    assign opnd.b = (b_sel_i == exec_op_pkg::B_IMM) ? imm_i : rt_fwd;

    assign store_data_o = rt_fwd;  // sw data always from rt

    assign opnd.valid = valid_i;
    assign opnd.op    = op_i;

endmodule

`default_nettype wire

//--- hdl/alu_logic.sv
// combinational ALU: pass, add/sub, bitwise logic and set-less-than
`default_nettype none
`include "exec_macros.svh"

module alu_logic (
    exec_operand_if.unit        opnd,
    output exec_data_pkg::word_t result_o
);

    localparam int unsigned W = `EXEC_WORD_W;

    logic [W:0] slt_diff;  // sign-extended A - B

    // one extra bit keeps the true sign even when A - B overflows
    assign slt_diff = {opnd.a[W-1], opnd.a} - {opnd.b[W-1], opnd.b};

    always_comb
    begin
        case (opnd.op)
            exec_op_pkg::ALU_PA:
                result_o = opnd.a;
            exec_op_pkg::ALU_PB:
                result_o = opnd.b;
            exec_op_pkg::ALU_ADD:
                result_o = opnd.a + opnd.b;
            exec_op_pkg::ALU_SUB:
                result_o = opnd.a - opnd.b;
            exec_op_pkg::ALU_AND:
                result_o = opnd.a & opnd.b;
            exec_op_pkg::ALU_OR:
                result_o = opnd.a | opnd.b;
            exec_op_pkg::ALU_XOR:
                result_o = opnd.a ^ opnd.b;
            exec_op_pkg::ALU_NOR:
                result_o = ~(opnd.a | opnd.b);
            exec_op_pkg::ALU_SLT:
                result_o = exec_data_pkg::word_t'(slt_diff[W]);  // negative means A < B
            exec_op_pkg::ALU_SLTU:
                result_o = exec_data_pkg::word_t'(opnd.a < opnd.b);
            default:
                result_o = '0;  // shifter or mul/div owns it
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/barrel_shifter.sv
// barrel shifter: sll, srl and sra of B by the low bits of A
`default_nettype none
`include "exec_macros.svh"

module barrel_shifter (
    exec_operand_if.unit        opnd,
    output exec_data_pkg::word_t result_o
);

    localparam int unsigned W  = `EXEC_WORD_W;
    localparam int unsigned SW = `EXEC_SHAMT_W;

    logic [SW-1:0]        shamt;
    logic                 fill;          // bit shifted in from the top
    exec_data_pkg::word_t stg [0:SW];    // one entry per log stage

    function automatic exec_data_pkg::word_t bit_rev(input exec_data_pkg::word_t v);
        exec_data_pkg::word_t r;
        for (int i = 0; i < W; i++)
        begin
            r[i] = v[W-1-i];
        end
        return r;
    endfunction

    assign shamt = opnd.a[SW-1:0];
    assign fill  = (opnd.op == exec_op_pkg::ALU_SRA) & opnd.b[W-1];

    // left shift runs through the same right shifter on a mirrored word
    assign stg[0] = (opnd.op == exec_op_pkg::ALU_SLL) ? bit_rev(opnd.b) : opnd.b;

    for (genvar i = 0; i < SW; i++)
    begin : g_stage
        assign stg[i+1] = shamt[i] ? {{(2**i){fill}}, stg[i][W-1:2**i]} : stg[i];
    end

    always_comb
    begin
        case (opnd.op)
            exec_op_pkg::ALU_SLL:
                result_o = bit_rev(stg[SW]);  // mirror back
            exec_op_pkg::ALU_SRL,
            exec_op_pkg::ALU_SRA:
                result_o = stg[SW];
            default:
                result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/muldiv_unit.sv
// iterative multiply/divide unit with the hi/lo pair and its move operations
`default_nettype none
`include "exec_macros.svh"

module muldiv_unit (
    input  wire                  clk,
    input  wire                  rst,
    exec_operand_if.unit         opnd,
    output exec_data_pkg::word_t result_o,
    output logic                 busy_o
);

    localparam int unsigned      W         = `EXEC_WORD_W;
    localparam int unsigned      CNT_W     = $clog2(`EXEC_MD_STEPS);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EXEC_MD_STEPS - 1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,   // one bit per cycle on magnitudes
        FIX    // apply result signs and write hi/lo
    } state_e;

    state_e                state_q;
    logic [CNT_W-1:0]      step_q;
    exec_data_pkg::hilo_t  hilo_q;
    exec_data_pkg::word_t  work_hi;    // partial product or remainder
    exec_data_pkg::word_t  work_lo;    // multiplier bits, then quotient bits
    exec_data_pkg::word_t  mag_m;      // multiplicand or divisor magnitude
    logic                  is_mul_q;
    logic                  neg_res_q;  // operand signs differ
    logic                  neg_rem_q;  // dividend was negative

    logic                  md_op;
    logic                  mul_op;
    logic                  mt_op;
    logic                  signed_op;
    logic                  start;
    exec_data_pkg::word_t  mag_a;
    exec_data_pkg::word_t  mag_b;
    logic [W:0]            mul_sum;
    logic [W:0]            div_shift;
    logic [W+1:0]          div_diff;
    exec_data_pkg::dword_t prod;
    exec_data_pkg::word_t  quot;
    exec_data_pkg::word_t  rem;

    assign mul_op    = (opnd.op == exec_op_pkg::ALU_MULT) || (opnd.op == exec_op_pkg::ALU_MULTU);
    assign md_op     = mul_op || (opnd.op == exec_op_pkg::ALU_DIV)
                       || (opnd.op == exec_op_pkg::ALU_DIVU);
    assign mt_op     = (opnd.op == exec_op_pkg::ALU_MTHI) || (opnd.op == exec_op_pkg::ALU_MTLO);
    assign signed_op = (opnd.op == exec_op_pkg::ALU_MULT) || (opnd.op == exec_op_pkg::ALU_DIV);

    assign busy_o = (state_q != IDLE);
    assign start  = opnd.valid && !busy_o && md_op;

    assign mag_a = (signed_op && opnd.a[W-1]) ? -opnd.a : opnd.a;
    assign mag_b = (signed_op && opnd.b[W-1]) ? -opnd.b : opnd.b;

    // shift-add step with the carry in bit W
    assign mul_sum   = {1'b0, work_hi} + (work_lo[0] ? {1'b0, mag_m} : '0);
    // restoring divide step with the borrow in the top bit
    assign div_shift = {work_hi, work_lo[W-1]};
    assign div_diff  = {1'b0, div_shift} - {2'b0, mag_m};

    assign prod = neg_res_q ? -{work_hi, work_lo} : {work_hi, work_lo};
    assign quot = neg_res_q ? -work_lo : work_lo;  // truncates toward zero
    assign rem  = neg_rem_q ? -work_hi : work_hi;  // sign follows dividend

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state_q <= IDLE;
            step_q  <= '0;
            hilo_q  <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    step_q <= '0;
                    if (start)
                        state_q <= RUN;
                    if (opnd.valid && mt_op)
                    begin
                        if (opnd.op == exec_op_pkg::ALU_MTHI)
                            hilo_q.hi <= opnd.a;
                        else
                            hilo_q.lo <= opnd.a;
                    end
                end
                RUN:
                begin
                    step_q <= step_q + 1'b1;
                    if (step_q == LAST_STEP)
                        state_q <= FIX;
                end
                FIX:
                begin
                    state_q <= IDLE;
                    if (is_mul_q)
                    begin
                        hilo_q.hi <= prod[2*W-1:W];
                        hilo_q.lo <= prod[W-1:0];
                    end
                    else
                    begin
                        hilo_q.hi <= rem;
                        hilo_q.lo <= quot;
                    end
                end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    // working registers loaded on issue
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            is_mul_q  <= mul_op;
            neg_res_q <= signed_op && (opnd.a[W-1] ^ opnd.b[W-1]);
            neg_rem_q <= signed_op && opnd.a[W-1];
            work_hi   <= '0;
            work_lo   <= mul_op ? mag_b : mag_a;
            mag_m     <= mul_op ? mag_a : mag_b;
        end
        else if (state_q == RUN)
        begin
            if (is_mul_q)
            begin
                work_hi <= mul_sum[W:1];
                work_lo <= {mul_sum[0], work_lo[W-1:1]};
            end
            else if (!div_diff[W+1])
            begin
                work_hi <= div_diff[W-1:0];
                work_lo <= {work_lo[W-2:0], 1'b1};
            end
            else
            begin
                work_hi <= div_shift[W-1:0];
                work_lo <= {work_lo[W-2:0], 1'b0};
            end
        end
    end

    always_comb
    begin
        case (opnd.op)
            exec_op_pkg::ALU_MFHI: result_o = hilo_q.hi;
            exec_op_pkg::ALU_MFLO: result_o = hilo_q.lo;
            default:               result_o = '0;
        endcase
    end

    // a busy period covers every step and ends through the sign-fix step
    a_busy_fall_from_fix: assert property (@(posedge clk) disable iff (!rst)
        $fell(busy_o) && $past(rst) |-> $past(state_q) == FIX
            && $past(busy_o, `EXEC_MD_STEPS + 1) && !$past(busy_o, `EXEC_MD_STEPS + 2))
        else $error("busy_o fell outside the FIX state or after the wrong number of cycles");

    // the issuer has no back-pressure and must hold off while busy
    a_no_issue_while_busy: assert property (@(posedge clk) disable iff (!rst)
        busy_o |-> !(opnd.valid && (md_op || mt_op)))
        else $error("mul/div or hi/lo move issued while busy_o is high");

endmodule

`default_nettype wire

//--- hdl/exec_unit.sv
// execute stage top: operand select feeding ALU, shifter and mul/div unit
`default_nettype none

module exec_unit (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        valid_i,
    input  wire exec_op_pkg::alu_op_e  op_i,
    input  wire exec_op_pkg::a_sel_e   a_sel_i,
    input  wire exec_op_pkg::b_sel_e   b_sel_i,
    input  wire exec_op_pkg::fwd_sel_e fwd_a_i,
    input  wire exec_op_pkg::fwd_sel_e fwd_b_i,
    input  wire exec_data_pkg::word_t  rs_i,
    input  wire exec_data_pkg::word_t  rt_i,
    input  wire exec_data_pkg::word_t  imm_i,
    input  wire exec_data_pkg::word_t  fw_alu_i,
    input  wire exec_data_pkg::word_t  fw_mem_i,
    output exec_data_pkg::word_t       result_o,
    output exec_data_pkg::word_t       store_data_o,
    output logic                       busy_o
);

    exec_data_pkg::word_t alu_res;
    exec_data_pkg::word_t shf_res;
    exec_data_pkg::word_t md_res;

    exec_operand_if opnd_if ();

    operand_select u_operand_select (
        .a_sel_i      (a_sel_i),
        .b_sel_i      (b_sel_i),
        .fwd_a_i      (fwd_a_i),
        .fwd_b_i      (fwd_b_i),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .rs_i         (rs_i),
        .rt_i         (rt_i),
        .imm_i        (imm_i),
        .fw_alu_i     (fw_alu_i),
        .fw_mem_i     (fw_mem_i),
        .store_data_o (store_data_o),
        .opnd         (opnd_if.src)
    );

    alu_logic u_alu_logic (
        .opnd     (opnd_if.unit),
        .result_o (alu_res)
    );

    barrel_shifter u_barrel_shifter (
        .opnd     (opnd_if.unit),
        .result_o (shf_res)
    );

    muldiv_unit u_muldiv_unit (
        .clk      (clk),
        .rst      (rst),
        .opnd     (opnd_if.unit),
        .result_o (md_res),
        .busy_o   (busy_o)
    );

    // units not owning the opcode drive zero
    assign result_o = alu_res | shf_res | md_res;

endmodule

`default_nettype wire

//--- tests/exec_vectors_tb.svh
// execute stage test table: stimulus, expected result and expected store data per entry
`ifndef EXEC_VECTORS_TB_SVH
`define EXEC_VECTORS_TB_SVH

string                 vec_name[$];
exec_op_pkg::alu_op_e  vec_op[$];
exec_op_pkg::a_sel_e   vec_asel[$];
exec_op_pkg::b_sel_e   vec_bsel[$];
exec_op_pkg::fwd_sel_e vec_fa[$];
exec_op_pkg::fwd_sel_e vec_fb[$];
exec_data_pkg::word_t  vec_rs[$];
exec_data_pkg::word_t  vec_rt[$];
exec_data_pkg::word_t  vec_imm[$];
exec_data_pkg::word_t  vec_res[$];
exec_data_pkg::word_t  vec_sd[$];
bit                    vec_wait[$];  // hold off until busy_o drops

task automatic add_vec(
    input string                 name,
    input exec_op_pkg::alu_op_e  op,
    input exec_data_pkg::word_t  rs,
    input exec_data_pkg::word_t  rt,
    input exec_data_pkg::word_t  res,
    input bit                    wt   = 1'b0,
    input exec_op_pkg::a_sel_e   asel = exec_op_pkg::A_RS,
    input exec_op_pkg::b_sel_e   bsel = exec_op_pkg::B_RT,
    input exec_op_pkg::fwd_sel_e fa   = exec_op_pkg::FWD_REG,
    input exec_op_pkg::fwd_sel_e fb   = exec_op_pkg::FWD_REG,
    input exec_data_pkg::word_t  imm  = '0
);
    vec_name.push_back(name);
    vec_op.push_back(op);
    vec_asel.push_back(asel);
    vec_bsel.push_back(bsel);
    vec_fa.push_back(fa);
    vec_fb.push_back(fb);
    vec_rs.push_back(rs);
    vec_rt.push_back(rt);
    vec_imm.push_back(imm);
    vec_res.push_back(res);
    vec_wait.push_back(wt);
    // store data is rt after its bypass select, never the immediate
    case (fb)
        exec_op_pkg::FWD_ALU: vec_sd.push_back(FW_ALU_VAL);
        exec_op_pkg::FWD_MEM: vec_sd.push_back(FW_MEM_VAL);
        default:              vec_sd.push_back(rt);
    endcase
endtask

// one mul/div issue, then reads of hi and lo from 64-bit reference arithmetic
task automatic add_muldiv(
    input exec_op_pkg::alu_op_e op,
    input exec_data_pkg::word_t x,
    input exec_data_pkg::word_t y
);
    longint      sx;
    longint      sy;
    logic [63:0] hl;  // expected {hi, lo}
    string       name;
    sx   = longint'($signed(x));
    sy   = longint'($signed(y));
    name = $sformatf("%s %h,%h", op.name(), x, y);
    case (op)
        exec_op_pkg::ALU_MULT:  hl = sx * sy;
        exec_op_pkg::ALU_MULTU: hl = {32'd0, x} * {32'd0, y};
        exec_op_pkg::ALU_DIV:   hl = {32'(sx % sy), 32'(sx / sy)};  // rem follows dividend
        default:                hl = {x % y, x / y};
    endcase
    add_vec(name, op, x, y, '0, 1'b1);
    add_vec({name, " hi"}, exec_op_pkg::ALU_MFHI, '0, '0, hl[63:32]);
    add_vec({name, " lo"}, exec_op_pkg::ALU_MFLO, '0, '0, hl[31:0]);
endtask

task automatic build_vectors();
    exec_data_pkg::word_t x;
    exec_data_pkg::word_t y;
    add_vec("mfhi after reset", exec_op_pkg::ALU_MFHI, '0, '0, '0);
    add_vec("mflo after reset", exec_op_pkg::ALU_MFLO, '0, '0, '0);
    add_vec("add", exec_op_pkg::ALU_ADD, 32'h7fff_ffff, 32'h0000_0001, 32'h8000_0000);
    add_vec("sub", exec_op_pkg::ALU_SUB, 32'h0000_0005, 32'h0000_0007, 32'hffff_fffe);
    add_vec("and", exec_op_pkg::ALU_AND, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200);
    add_vec("or", exec_op_pkg::ALU_OR, 32'hf0f0_1234, 32'h0ff0_ff00, 32'hfff0_ff34);
    add_vec("xor", exec_op_pkg::ALU_XOR, 32'hf0f0_1234, 32'h0ff0_ff00, 32'hff00_ed34);
    add_vec("nor", exec_op_pkg::ALU_NOR, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h000f_00cb);
    add_vec("slt -16,16", exec_op_pkg::ALU_SLT, 32'hffff_fff0, 32'h0000_0010, 32'd1);
    add_vec("sltu -16,16", exec_op_pkg::ALU_SLTU, 32'hffff_fff0, 32'h0000_0010, 32'd0);
    add_vec("slt min,max", exec_op_pkg::ALU_SLT, 32'h8000_0000, 32'h7fff_ffff, 32'd1);
    add_vec("sltu min,max", exec_op_pkg::ALU_SLTU, 32'h8000_0000, 32'h7fff_ffff, 32'd0);
    // shift amount is A[4:0], upper A bits must not matter
    add_vec("sll 0", exec_op_pkg::ALU_SLL, 32'd0, 32'h8765_4321, 32'h8765_4321);
    add_vec("sll 4", exec_op_pkg::ALU_SLL, 32'hffff_ffe4, 32'h8765_4321, 32'h7654_3210);
    add_vec("sll 31", exec_op_pkg::ALU_SLL, 32'd31, 32'h0000_0003, 32'h8000_0000);
    add_vec("srl 4", exec_op_pkg::ALU_SRL, 32'd4, 32'h8765_4321, 32'h0876_5432);
    add_vec("srl 31", exec_op_pkg::ALU_SRL, 32'd31, 32'h8000_0000, 32'h0000_0001);
    add_vec("sra 0", exec_op_pkg::ALU_SRA, 32'd0, 32'h8765_4321, 32'h8765_4321);
    add_vec("sra 4", exec_op_pkg::ALU_SRA, 32'd4, 32'h8765_4321, 32'hf876_5432);
    add_vec("sra 31", exec_op_pkg::ALU_SRA, 32'd31, 32'h8000_0000, 32'hffff_ffff);
    add_vec("pa fwd alu", exec_op_pkg::ALU_PA, 32'h1111_1111, 32'h2222_2222, FW_ALU_VAL, 1'b0,
            exec_op_pkg::A_RS, exec_op_pkg::B_RT, exec_op_pkg::FWD_ALU, exec_op_pkg::FWD_REG);
    add_vec("pa fwd mem", exec_op_pkg::ALU_PA, 32'h1111_1111, 32'h2222_2222, FW_MEM_VAL, 1'b0,
            exec_op_pkg::A_RS, exec_op_pkg::B_RT, exec_op_pkg::FWD_MEM, exec_op_pkg::FWD_ALU);
    add_vec("pb fwd mem", exec_op_pkg::ALU_PB, 32'h1111_1111, 32'h2222_2222, FW_MEM_VAL, 1'b0,
            exec_op_pkg::A_RS, exec_op_pkg::B_RT, exec_op_pkg::FWD_REG, exec_op_pkg::FWD_MEM);
    add_vec("pb fwd alu", exec_op_pkg::ALU_PB, 32'h1111_1111, 32'h2222_2222, FW_ALU_VAL, 1'b0,
            exec_op_pkg::A_RS, exec_op_pkg::B_RT, exec_op_pkg::FWD_REG, exec_op_pkg::FWD_ALU);
    add_vec("pa imm", exec_op_pkg::ALU_PA, 32'h1111_1111, 32'h2222_2222, 32'h0000_abcd, 1'b0,
            exec_op_pkg::A_IMM, exec_op_pkg::B_RT, exec_op_pkg::FWD_MEM, exec_op_pkg::FWD_REG,
            32'h0000_abcd);
    add_vec("pb imm", exec_op_pkg::ALU_PB, 32'h1111_1111, 32'h2222_2222, 32'hffff_8001, 1'b0,
            exec_op_pkg::A_RS, exec_op_pkg::B_IMM, exec_op_pkg::FWD_REG, exec_op_pkg::FWD_ALU,
            32'hffff_8001);
    add_muldiv(exec_op_pkg::ALU_MULT, 32'hffff_ffff, 32'hffff_ffff);
    add_muldiv(exec_op_pkg::ALU_MULTU, 32'hffff_ffff, 32'hffff_ffff);
    add_muldiv(exec_op_pkg::ALU_MULT, 32'h8000_0000, 32'h8000_0000);
    add_muldiv(exec_op_pkg::ALU_DIV, 32'hffff_fff9, 32'h0000_0002);
    add_muldiv(exec_op_pkg::ALU_DIV, 32'h0000_0007, 32'hffff_fffe);
    add_muldiv(exec_op_pkg::ALU_DIVU, 32'hffff_fff9, 32'h0000_0002);
    repeat (3)
    begin
        x = $random(seed);
        y = $random(seed);
        add_muldiv(exec_op_pkg::ALU_MULT, x, y);
        add_muldiv(exec_op_pkg::ALU_MULTU, x, y);
        if (y == '0)
            y = 32'd1;  // divide by zero has no defined result
        add_muldiv(exec_op_pkg::ALU_DIV, x, y);
        add_muldiv(exec_op_pkg::ALU_DIVU, x, y);
    end
    add_vec("mthi", exec_op_pkg::ALU_MTHI, 32'h1357_9bdf, '0, '0);
    add_vec("mtlo", exec_op_pkg::ALU_MTLO, 32'h2468_ace0, '0, '0);
    add_vec("mfhi after mthi", exec_op_pkg::ALU_MFHI, '0, '0, 32'h1357_9bdf);
    add_vec("mflo after mtlo", exec_op_pkg::ALU_MFLO, '0, '0, 32'h2468_ace0);
endtask

`endif

//--- tests/exec_unit_tb.sv
// execute stage testbench with table driven checks of operand select, ALU, shifter and mul/div
`default_nettype none

module exec_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned          CLK_PERIOD = 40;
    localparam exec_data_pkg::word_t FW_ALU_VAL = 32'ha1a1_0001;  // ALU-stage bypass value
    localparam exec_data_pkg::word_t FW_MEM_VAL = 32'h3e3e_0002;  // memory-stage bypass value

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  valid_i;
    exec_op_pkg::alu_op_e  op_i;
    exec_op_pkg::a_sel_e   a_sel_i;
    exec_op_pkg::b_sel_e   b_sel_i;
    exec_op_pkg::fwd_sel_e fwd_a_i;
    exec_op_pkg::fwd_sel_e fwd_b_i;
    exec_data_pkg::word_t  rs_i;
    exec_data_pkg::word_t  rt_i;
    exec_data_pkg::word_t  imm_i;
    exec_data_pkg::word_t  fw_alu_i;
    exec_data_pkg::word_t  fw_mem_i;
    exec_data_pkg::word_t  result_o;
    exec_data_pkg::word_t  store_data_o;
    logic                  busy_o;
    int                    seed = 32'h3f7e_6243;
    bit                    table_ready = 1'b0;

    `include "exec_vectors_tb.svh"

    exec_unit DUT (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    // drive on the falling edge, check in the low phase, then sit out a mul/div
    task automatic apply_vector(input int i);
        valid_i = 1'b1;
        op_i    = vec_op[i];
        a_sel_i = vec_asel[i];
        b_sel_i = vec_bsel[i];
        fwd_a_i = vec_fa[i];
        fwd_b_i = vec_fb[i];
        rs_i    = vec_rs[i];
        rt_i    = vec_rt[i];
        imm_i   = vec_imm[i];
        #(CLK_PERIOD/4);
        assert (result_o === vec_res[i])
        else stop_run($sformatf("ERR %s result expected %h actual %h",
                                vec_name[i], vec_res[i], result_o));
        assert (store_data_o === vec_sd[i])
        else stop_run($sformatf("ERR %s store data expected %h actual %h",
                                vec_name[i], vec_sd[i], store_data_o));
        @(negedge clk);
        if (vec_wait[i])
        begin
            valid_i = 1'b0;
            op_i    = exec_op_pkg::ALU_NOP;
            assert (busy_o === 1'b1)
            else stop_run($sformatf("ERR %s busy_o expected 1 actual %b",
                                    vec_name[i], busy_o));
            while (busy_o !== 1'b0)
                @(negedge clk);  // hi/lo written where busy_o falls
        end
    endtask

    initial
    begin
        rst      = 1'b0;
        valid_i  = 1'b0;
        op_i     = exec_op_pkg::ALU_NOP;
        a_sel_i  = exec_op_pkg::A_RS;
        b_sel_i  = exec_op_pkg::B_RT;
        fwd_a_i  = exec_op_pkg::FWD_REG;
        fwd_b_i  = exec_op_pkg::FWD_REG;
        rs_i     = '0;
        rt_i     = '0;
        imm_i    = '0;
        fw_alu_i = FW_ALU_VAL;
        fw_mem_i = FW_MEM_VAL;
        build_vectors();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        assert (busy_o === 1'b0)
        else stop_run($sformatf("ERR reset busy_o expected 0 actual %b", busy_o));
        for (int i = 0; i < vec_name.size(); i++)
        begin
            apply_vector(i);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog allows 40 cycles per table entry
    initial
    begin
        wait (table_ready);
        #(vec_name.size() * 40 * CLK_PERIOD);
        stop_run("timeout: the test table did not complete in the allowed time");
    end

endmodule

`default_nettype wire

//--- exec_unit.f
+incdir+hdl
+incdir+tests
hdl/exec_op_pkg.sv
hdl/exec_data_pkg.sv
hdl/exec_operand_if.sv
hdl/operand_select.sv
hdl/alu_logic.sv
hdl/barrel_shifter.sv
hdl/muldiv_unit.sv
hdl/exec_unit.sv
tests/exec_unit_tb.sv
